//--- build.f
+incdir+hw
hw/ese_pkg.sv
hw/ese_ram_mapper.sv
hw/sd_spi_shifter.sv
hw/cartridge_ram.sv
hw/ese_cartridge_top.sv
testbench/sd_card_model.sv
testbench/tb_ese_cartridge.sv

//--- hw/cartridge_ram.sv
`timescale 1ns/10ps

`include "ese_macros.svh"

module cartridge_ram (
    input  logic              cpu_bus,
    input  ese_pkg::mem_req_t mem,
    output logic [7:0]        rdata
);

    localparam int DEPTH = 1 << `ESE_RAM_AW;

    logic [7:0]             ram [DEPTH];
    logic [`ESE_RAM_AW-1:0] word_addr;

    // Bank bits above the array size fall away here
    assign word_addr = mem.addr[`ESE_RAM_AW-1:0];

    // Writes land at the request edge
    // Read data appears one cycle later and holds until the next read
    always_ff @(posedge cpu_bus) begin
        if (mem.ram_cs) begin
            if (!mem.rnw) begin
                ram[word_addr] <= mem.wdata;
            end else begin
                rdata <= ram[word_addr];
            end
        end
    end

endmodule

//--- hw/ese_cartridge_top.sv
`timescale 1ns/10ps

module ese_cartridge_top (
    input  logic              cpu_bus,
    input  logic              rst_n,
    input  ese_pkg::cpu_req_t bus,
    output logic [7:0]        rdata,
    output logic              sclk,
    output logic              mosi,
    output logic              cs_n,
    input  logic              miso
);
    import ese_pkg::*;

    mem_req_t   mem;
    sd_cmd_t    sd_cmd;
    rd_src_t    rd_src;
    rd_src_t    rd_src_q;
    logic       rd_q;
    logic [7:0] ram_rdata;
    logic [7:0] data_from_sd;
    logic [7:0] rd_mux;
    logic [7:0] rdata_hold;

    ese_ram_mapper u_mapper (
        .cpu_bus (cpu_bus),
        .rst_n   (rst_n),
        .bus     (bus),
        .mem     (mem),
        .sd_cmd  (sd_cmd),
        .rd_src  (rd_src)
    );

    cartridge_ram u_ram (
        .cpu_bus (cpu_bus),
        .mem     (mem),
        .rdata   (ram_rdata)
    );

    sd_spi_shifter u_shifter (
        .cpu_bus      (cpu_bus),
        .rst_n        (rst_n),
        .sd_cmd       (sd_cmd),
        .sclk         (sclk),
        .mosi         (mosi),
        .cs_n         (cs_n),
        .miso         (miso),
        .data_from_sd (data_from_sd)
    );

    // The select is delayed to line up with the registered RAM data
    always_ff @(posedge cpu_bus) begin
        if (!rst_n) begin
            rd_q       <= 1'b0;
            rd_src_q   <= RD_RAM;
            rdata_hold <= 8'hFF;
        end else begin
            rd_q     <= bus.req && bus.rd;
            rd_src_q <= rd_src;
            // Keep the last read value on the bus between reads
            if (rd_q) begin
                rdata_hold <= rd_mux;
            end
        end
    end

    // The SD byte cannot change here, as an exchange needs 16 more cycles
    assign rd_mux = (rd_src_q == RD_SD) ? data_from_sd : ram_rdata;

    // Valid in the cycle after the request for both sources
    assign rdata = rd_q ? rd_mux : rdata_hold;

endmodule

//--- hw/ese_macros.svh
`ifndef ESE_MACROS_SVH
`define ESE_MACROS_SVH

// Word address width of the cartridge RAM
// 17 bits give 128 KiB, and bank bits above this width are dropped
`define ESE_RAM_AW 17

// Bits shifted per SPI exchange with the card
`define ESE_SPI_BITS 8

// Bank register 0 bits 7:6 must hold this code to open the SD window
`define ESE_SD_MODE 2'b01

// Value of addr[14:13] that selects the bank register window at 6000h-7FFFh
`define ESE_BANK_WIN 2'b11

// Value of addr[14:13] for page 4000h, which becomes the SD window when it is open
`define ESE_SD_PAGE 2'b10

// Value of addr[12:11] that selects the mode register at 5800h-5FFFh
`define ESE_MODE_SEL 2'b11

`endif

//--- hw/ese_pkg.sv
package ese_pkg;

    // One cycle of Z80-style bus activity
    // An access has req high with exactly one of rd or wr set
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  data;
        logic        rd;
        logic        wr;
        logic        req;
    } cpu_req_t;

    // Request from the mapper to the cartridge RAM
    // The addr is the full 27-bit mapper address and the RAM keeps only its low bits
    typedef struct packed {
        logic        ram_cs;
        logic        rnw;
        logic [26:0] addr;
        logic [7:0]  wdata;
    } mem_req_t;

    // Command from the mapper to the SPI shifter
    // rx is a one-cycle strobe that starts an exchange
    // tx marks a write, otherwise the shifter sends FFh
    // cs_n is a level taken from address bit 12
    typedef struct packed {
        logic       rx;
        logic       tx;
        logic [7:0] data_to_sd;
        logic       cs_n;
    } sd_cmd_t;

    // Source of the bus read data
    typedef enum logic {
        RD_RAM,
        RD_SD
    } rd_src_t;

endpackage

//--- hw/ese_ram_mapper.sv
`timescale 1ns/10ps

`include "ese_macros.svh"

module ese_ram_mapper (
    input  logic              cpu_bus,
    input  logic              rst_n,
    input  ese_pkg::cpu_req_t bus,
    output ese_pkg::mem_req_t mem,
    output ese_pkg::sd_cmd_t  sd_cmd,
    output ese_pkg::rd_src_t  rd_src
);
    import ese_pkg::*;

    // Four bank registers whose bit 7 enables writes in the page
    logic [7:0] bank [4];

    // Mode bit that keeps the card quiet when set
    logic       sd_mute;

    // Registered command toward the shifter
    logic       rx_q;
    logic       tx_q;
    logic       cs_n_q;
    logic [7:0] data_to_sd_q;

    // Decoded view of the current access
    logic [1:0] page_idx;
    logic [7:0] bank_sel;
    logic       page_we;
    logic       bank_win;
    logic       sd_window;
    logic       mode_sel;
    logic       ram_wr;
    logic       ram_rd;
    logic       sd_access;

    // Pages 8000h, A000h, 4000h and 6000h use bank registers 2, 3, 0 and 1
    // Inverting addr[14] and keeping addr[13] gives exactly that index
    // Bit 15 is not decoded, so 0000h-3FFFh alias the upper pages
    assign page_idx = {~bus.addr[14], bus.addr[13]};
    assign bank_sel = bank[page_idx];

    // Page 6000h holds the register window and never stores data
    assign page_we = bank_sel[7] && (page_idx != 2'd1);

    // Writes at 6000h-7FFFh land in the bank registers
    assign bank_win = (bus.addr[14:13] == `ESE_BANK_WIN);

    // Page 4000h turns into the SD port when bank 0 carries the SD code
    assign sd_window = (bank[0][7:6] == `ESE_SD_MODE) && (bus.addr[14:13] == `ESE_SD_PAGE);
    assign mode_sel  = (bus.addr[12:11] == `ESE_MODE_SEL);

    // The SD code keeps bit 7 of bank 0 clear, so SD writes never reach the RAM
    assign ram_wr = bus.req && bus.wr && page_we;

    // Reads in the open SD window come from the shifter instead
    assign ram_rd = bus.req && bus.rd && !sd_window;

    // Data accesses at 4000h-57FFh start an exchange unless the card is muted
    assign sd_access = bus.req && (bus.rd || bus.wr) && sd_window && !mode_sel && !sd_mute;

    // The RAM address puts the bank base above the 8 KiB page offset
    assign mem.ram_cs = ram_wr || ram_rd;
    assign mem.rnw    = !ram_wr;
    assign mem.addr   = {7'd0, bank_sel[6:0], bus.addr[12:0]};
    assign mem.wdata  = bus.data;

    // The top delays this select by one cycle to meet the read data
    assign rd_src = sd_window ? RD_SD : RD_RAM;

    // Bank registers take the new value from the next cycle on
    always_ff @(posedge cpu_bus) begin
        if (!rst_n) begin
            bank <= '{8'h00, 8'h00, 8'h00, 8'h00};
        end else if (bus.req && bus.wr && bank_win) begin
            bank[bus.addr[12:11]] <= bus.data;
        end
    end

    // Mode register and command strobes
    always_ff @(posedge cpu_bus) begin
        if (!rst_n) begin
            sd_mute <= 1'b0;
            rx_q    <= 1'b0;
            tx_q    <= 1'b0;
            cs_n_q  <= 1'b1;
        end else begin
            // Strobes last a single cycle
            rx_q <= sd_access;
            tx_q <= sd_access && bus.wr;

            // Chip select follows address bit 12 of the last exchange
            if (sd_access) begin
                cs_n_q <= bus.addr[12];
            end

            // Only bit 0 of the mode register is kept
            if (bus.req && bus.wr && sd_window && mode_sel) begin
                sd_mute <= bus.data[0];
            end
        end
    end

    // Bus data of the access, which the shifter replaces by FFh when tx is clear
    always_ff @(posedge cpu_bus) begin
        if (sd_access) begin
            data_to_sd_q <= bus.data;
        end
    end

    assign sd_cmd.rx         = rx_q;
    assign sd_cmd.tx         = tx_q;
    assign sd_cmd.data_to_sd = data_to_sd_q;
    assign sd_cmd.cs_n       = cs_n_q;

endmodule

//--- hw/sd_spi_shifter.sv
`timescale 1ns/10ps

`include "ese_macros.svh"

module sd_spi_shifter (
    input  logic             cpu_bus,
    input  logic             rst_n,
    input  ese_pkg::sd_cmd_t sd_cmd,
    output logic             sclk,
    output logic             mosi,
    output logic             cs_n,
    input  logic             miso,
    output logic [7:0]       data_from_sd
);

    // Counter runs from 0 up to the full bit count
    localparam int CNT_W = $clog2(`ESE_SPI_BITS + 1);

    logic                     busy;
    logic [CNT_W-1:0]         bit_cnt;
    logic                     sclk_q;
    logic                     cs_n_q;
    logic [`ESE_SPI_BITS-1:0] tx_sh;
    logic [`ESE_SPI_BITS-1:0] rx_sh;

    // SPI mode 0, MSB first
    // mosi is valid before the first rising edge and moves on each falling edge
    assign sclk = sclk_q;
    assign mosi = tx_sh[`ESE_SPI_BITS-1];
    assign cs_n = cs_n_q;

    // Exchange control
    // sclk toggles every cycle, so one byte takes 16 cycles
    always_ff @(posedge cpu_bus) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            bit_cnt <= '0;
            sclk_q  <= 1'b0;
            cs_n_q  <= 1'b1;
            tx_sh   <= '1;
        end else if (!busy) begin
            // A command is accepted only while idle
            if (sd_cmd.rx) begin
                busy    <= 1'b1;
                bit_cnt <= '0;
                cs_n_q  <= sd_cmd.cs_n;
                tx_sh   <= sd_cmd.tx ? sd_cmd.data_to_sd : '1;
            end
        end else if (!sclk_q) begin
            // Rising edge, the bit is captured below
            sclk_q  <= 1'b1;
            bit_cnt <= bit_cnt + CNT_W'(1);
        end else begin
            sclk_q <= 1'b0;
            // The last falling edge closes the exchange
            if (bit_cnt == CNT_W'(`ESE_SPI_BITS)) begin
                busy <= 1'b0;
            end else begin
                tx_sh <= {tx_sh[`ESE_SPI_BITS-2:0], 1'b1};
            end
        end
    end

    // Receive path
    // miso is sampled on the clock edge that raises sclk
    always_ff @(posedge cpu_bus) begin
        if (busy && !sclk_q) begin
            rx_sh <= {rx_sh[`ESE_SPI_BITS-2:0], miso};
            // Held byte updates with the eighth captured bit
            if (bit_cnt == CNT_W'(`ESE_SPI_BITS - 1)) begin
                data_from_sd <= {rx_sh[`ESE_SPI_BITS-2:0], miso};
            end
        end
    end

endmodule

//--- testbench/sd_card_model.sv
`timescale 1ns/10ps

module sd_card_model (
    input  logic sclk,
    input  logic mosi,
    input  logic cs_n,
    output logic miso
);

    logic [7:0] rx_sh;
    logic [7:0] tx_sh;
    logic [7:0] reply;
    int         bit_cnt;

    // Nothing has been received yet, so the first answer is 00h XOR A5h
    initial begin
        rx_sh   = 8'h00;
        tx_sh   = 8'hA5;
        reply   = 8'hA5;
        bit_cnt = 0;
    end

    // A deselected card leaves the line pulled high
    assign miso = cs_n ? 1'b1 : tx_sh[7];

    // Mode 0 slave, mosi is taken on the rising edge
    always @(posedge sclk) begin
        if (!cs_n) begin
            rx_sh   = {rx_sh[6:0], mosi};
            bit_cnt = bit_cnt + 1;
            // The answer to the next byte is this byte XOR A5h
            if (bit_cnt == 8) begin
                reply = rx_sh ^ 8'hA5;
            end
        end
    end

    // miso moves on the falling edge, and the last one loads the next answer
    always @(negedge sclk) begin
        if (!cs_n) begin
            if (bit_cnt == 8) begin
                bit_cnt = 0;
                tx_sh   = reply;
            end else begin
                tx_sh = {tx_sh[6:0], 1'b1};
            end
        end
    end

endmodule

//--- testbench/tb_ese_cartridge.sv
`timescale 1ns/10ps

`include "ese_macros.svh"

module tb_ese_cartridge;
    import ese_pkg::*;

    logic       cpu_bus = 1'b0;
    logic       rst_n;
    cpu_req_t   bus;
    logic [7:0] rdata;
    logic       sclk;
    logic       mosi;
    logic       cs_n;
    logic       miso;

    // Models of the bank registers, the RAM and the card
    logic [7:0] bank_model [4];
    logic [7:0] ram_model [int];
    logic [7:0] card_prev;
    logic [7:0] held;
    logic       muted;

    // What the card saw on the wire
    logic [7:0] mosi_byte;
    logic       last_cs_n;
    int         sclk_edges = 0;

    int         checks = 0;
    int         errors = 0;
    int         test_checks = 0;
    int         test_errors = 0;

    ese_cartridge_top dut (
        .cpu_bus (cpu_bus),
        .rst_n   (rst_n),
        .bus     (bus),
        .rdata   (rdata),
        .sclk    (sclk),
        .mosi    (mosi),
        .cs_n    (cs_n),
        .miso    (miso)
    );

    sd_card_model card (
        .sclk (sclk),
        .mosi (mosi),
        .cs_n (cs_n),
        .miso (miso)
    );

    always #2 cpu_bus = ~cpu_bus;

    // Bits are recorded where the card samples them
    always @(posedge sclk) begin
        sclk_edges <= sclk_edges + 1;
        mosi_byte  <= {mosi_byte[6:0], mosi};
        last_cs_n  <= cs_n;
    end

    // Pages 4000h, 6000h, 8000h and A000h use registers 0 to 3 and bit 15 is ignored
    function automatic logic [1:0] page_reg(input logic [15:0] addr);
        case (addr[14:13])
            2'b10: return 2'd0;
            2'b11: return 2'd1;
            2'b00: return 2'd2;
            default: return 2'd3;
        endcase
    endfunction

    // Bank bits 6:0 sit above the 8 KiB offset and bits beyond the RAM size fall away
    function automatic int map_addr(input logic [15:0] addr, input logic [7:0] banks [4]);
        return {banks[page_reg(addr)][6:0], addr[12:0]} & ((1 << `ESE_RAM_AW) - 1);
    endfunction

    // A page is writable when bit 7 of its register is set, and page 6000h never is
    function automatic logic is_writable(input logic [15:0] addr, input logic [7:0] banks [4]);
        return (page_reg(addr) != 2'd1) && banks[page_reg(addr)][7];
    endfunction

    function automatic logic [7:0] sd_reply(input logic [7:0] last_rx);
        return last_rx ^ 8'hA5;
    endfunction

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
        checks++;
        test_checks++;
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s, got %0h, expected %0h", $time, msg, actual, expected);
            errors++;
            test_errors++;
        end
    endtask

    task automatic report_test(input string name);
        $display("%-30s %0d checks, %0d errors", name, test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
        @(posedge cpu_bus);
        bus <= {addr, data, 1'b0, 1'b1, 1'b1};
        @(posedge cpu_bus);
        bus <= '0;
    endtask

    task automatic bus_read(input logic [15:0] addr, output logic [7:0] data);
        @(posedge cpu_bus);
        bus <= {addr, 8'h00, 1'b1, 1'b0, 1'b1};
        @(posedge cpu_bus);
        bus <= '0;
        // rdata is valid through the cycle after the request
        @(negedge cpu_bus);
        data = rdata;
    endtask

    // Writes at 6000h-7FFFh go to a bank register and others go to RAM if the page allows
    task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
        bus_write(addr, data);
        if (addr[14:13] == 2'b11) begin
            bank_model[addr[12:11]] = data;
        end else if (is_writable(addr, bank_model)) begin
            ram_model[map_addr(addr, bank_model)] = data;
        end
    endtask

    task automatic ram_check(input logic [15:0] addr, input string msg);
        logic [7:0] got;
        bus_read(addr, got);
        check(got, ram_model[map_addr(addr, bank_model)], $sformatf("%s at %h", msg, addr));
    endtask

    // Runs one SD access and then waits for its exchange to end
    task automatic sd_op(input logic [15:0] addr, input logic wr, input logic [7:0] data);
        int         start;
        int         cycles;
        logic [7:0] got;
        logic [7:0] sent;
        start = sclk_edges;
        sent  = wr ? data : 8'hFF;
        if (wr) begin
            bus_write(addr, data);
        end else begin
            bus_read(addr, got);
            check(got, held, $sformatf("SD read at %h", addr));
        end
        if (muted) begin
            repeat (20) @(posedge cpu_bus);
            check(sclk_edges - start, 0, "sclk edges while muted");
        end else begin
            cycles = 0;
            while (sclk_edges < start + `ESE_SPI_BITS && cycles < 40) begin
                @(negedge cpu_bus);
                cycles++;
            end
            if (sclk_edges < start + `ESE_SPI_BITS) begin
                $display("Timeout: the SPI exchange for the access at %h never finished", addr);
                $display("*** TEST FAILED ***");
                $finish;
            end else begin
                check(mosi_byte, sent, "byte on mosi");
                check(last_cs_n, addr[12], "cs_n during exchange");
                // A deselected card leaves miso high and keeps its last byte
                if (!addr[12]) begin
                    held      = sd_reply(card_prev);
                    card_prev = sent;
                end else begin
                    held = 8'hFF;
                end
                // The shifter goes idle on the falling edge after the last bit
                repeat (3) @(posedge cpu_bus);
            end
        end
    endtask

    initial begin
        logic [15:0] addr;
        logic [7:0]  data;
        logic [6:0]  base;
        logic [2:0]  pages [3];
        logic [15:0] wr_addrs [$];
        pages      = '{3'b010, 3'b100, 3'b101};
        rst_n      = 1'b0;
        bus        = '0;
        bank_model = '{default: 8'h00};
        card_prev  = 8'h00;
        held       = 8'hxx;
        muted      = 1'b0;
        void'($urandom(4884));
        repeat (2) @(posedge cpu_bus);
        rst_n <= 1'b1;

        // Test 1 seeds one byte through a briefly enabled bank 0 and then reads every page
        addr = {3'b010, 13'($urandom)};
        data = 8'($urandom);
        cpu_write(16'h6000, 8'h80);
        cpu_write(addr, data);
        cpu_write(16'h6000, 8'h00);
        for (int p = 2; p < 6; p++) begin
            ram_check(16'(p << 13) | {3'b000, addr[12:0]}, "reset page alias");
        end
        cpu_write({3'b100, addr[12:0]}, ~data);
        ram_check({3'b100, addr[12:0]}, "write to disabled page");
        report_test("reset mapping and protect");

        // Test 2 sets random bases with writes enabled
        for (int r = 0; r < 4; r++) begin
            if (r != 1) begin
                cpu_write(16'h6000 | 16'(r << 11), {1'b1, 7'($urandom)});
            end
        end
        for (int i = 0; i < 6; i++) begin
            addr = {pages[i % 3], 13'($urandom)};
            cpu_write(addr, 8'($urandom));
            wr_addrs.push_back(addr);
        end
        foreach (wr_addrs[i]) begin
            ram_check(wr_addrs[i] ^ 16'h8000, "bit 15 alias");
        end
        // Bank 3 takes the base of bank 2 so page A000h shows the page 8000h data
        cpu_write(16'h7800, bank_model[2]);
        foreach (wr_addrs[i]) begin
            if (wr_addrs[i][14:13] == 2'b00) begin
                ram_check(wr_addrs[i] | 16'h2000, "bank 3 copy of bank 2");
            end
        end
        report_test("bank switching");

        // In test 3 the same offset in page 6000h lands in bank register 3
        base = 7'($urandom);
        cpu_write(16'h6800, {1'b1, base});
        cpu_write(16'h7000, {1'b1, base});
        addr = {3'b100, 2'b11, 11'($urandom)};
        cpu_write(addr, {1'b0, 7'($urandom)});
        cpu_write({3'b011, addr[12:0]}, {1'b1, base});
        ram_check({3'b011, addr[12:0]}, "page 6000h read");
        ram_check({3'b101, addr[12:0]}, "page A000h after remap");
        report_test("page 6000h stores nothing");

        // In test 4 the code 01 in bank 0 opens the SD window
        cpu_write(16'h6000, 8'h40);
        sd_op(16'h4000, 1'b1, 8'($urandom));
        sd_op(16'h4000, 1'b0, 8'h00);
        sd_op(16'h4000, 1'b0, 8'h00);
        sd_op(16'h5000, 1'b0, 8'h00);
        sd_op(16'h4000, 1'b0, 8'h00);
        report_test("SD window");

        // In test 5 the mode bit silences the card and clearing it restores traffic
        bus_write(16'h5800, 8'h01);
        muted = 1'b1;
        sd_op(16'h4000, 1'b1, 8'($urandom));
        sd_op(16'h4000, 1'b0, 8'h00);
        bus_write(16'h5800, 8'h00);
        muted = 1'b0;
        sd_op(16'h4000, 1'b1, 8'($urandom));
        sd_op(16'h4000, 1'b0, 8'h00);
        report_test("SD mode bit");

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
